//--- list.f
+incdir+design
+incdir+bench
design/MulDivOpTypes.sv
design/MulDivPipeTypes.sv
design/MulDivIssue.sv
design/MulUnit.sv
design/DivUnit.sv
design/MulDivUnit.sv
design/MulDivWriteback.sv
design/MulDivTop.sv
bench/MulDivTb.sv

//--- bench/MulDivModel.svh
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// ############################################################
// Reference results, 64-bit arithmetic plus the RV32M corner rules.
// ############################################################

function automatic logic [31:0] expectValue(input Rv32mFunct3 op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ua;
    logic [63:0]        ub;
    logic [63:0]        p;
    logic               divZero;
    logic               overflow;
    sa = {{32{a[31]}}, a};                                 // Sign extended.
    sb = {{32{b[31]}}, b};
    ua = {32'd0, a};                                       // Zero extended.
    ub = {32'd0, b};
    divZero = (b == 32'd0);
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
        Funct3Mul, Funct3Mulhu: p = ua * ub;
        Funct3Mulh:             p = sa * sb;
        Funct3Mulhsu:           p = sa * ub;               // Low 64 bits are exact.
        Funct3Div:              p = sa / sb;               // Truncates toward zero.
        Funct3Divu:             p = ua / ub;
        Funct3Rem:              p = sa % sb;               // Sign of the dividend.
        default:                p = ua % ub;
    endcase
    if (op[2] && divZero) begin
        p = op[1] ? ua : 64'hffff_ffff;                    // Remainder is the dividend.
    end
    if ((op == Funct3Div || op == Funct3Rem) && overflow) begin
        p = op[1] ? 64'd0 : ua;                            // Quotient is the dividend.
    end
    if (op == Funct3Mulh || op == Funct3Mulhsu || op == Funct3Mulhu) begin
        return p[63:32];
    end
    return p[31:0];
endfunction

// Cycles from acceptance to rspValid without stall.
function automatic int baseLatency(input Rv32mFunct3 op);
    return op[2] ? 1 + `MULDIV_XLEN + 2 : 1 + `MULDIV_MUL_LATENCY + 1;
endfunction

`endif

//--- bench/MulDivTb.sv
`timescale 1ns/100ps
`include "MulDiv_consts.svh"

module MulDivTb
    import MulDivOpTypes::*;
    import MulDivPipeTypes::*;
();
    localparam int NumRandom = 48;
    localparam int NumOps = NumRandom + 200 + 4 + 2 + 4;  // Random, corners, stall, hold, flush.
    localparam int ExtraCycles = 100;                     // Stall, hold and flush idle time.
    localparam int TimeLimit = (NumOps * 40 + ExtraCycles + 200) * 10;

    logic clk, rst, reqValid, reqReady, rspValid, rspReady, stall, flush;
    MulDivRequest  req;
    MulDivResponse rsp;
    MulDivResponse expectQ[$];                            // Scoreboard with one entry per request.
    MulDivResponse want;
    MulDivResponse heldRsp;
    int   seed, cyc, acceptCyc, stallCnt, expLatency;
    int   errors, errorsAtStart, passCount, failCount;
    logic inFlight, prevRspValid, prevHeld, readyDue;
    logic [`MULDIV_TAG_W-1:0] nextTag;
    logic [31:0] corner [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    `include "MulDivModel.svh"

    MulDivTop u_MulDivTop (
        .clk, .rst, .reqValid, .req, .reqReady, .rspValid, .rsp, .rspReady, .stall, .flush
    );

    always #5 clk = ~clk;

    task automatic mismatch(input string name, input logic [63:0] expected, actual);
        errors++;
        $display("[ERROR] %0t ns %s: expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
    endtask

    task automatic protocolError(input string what);
        errors++;
        $display("Protocol error at %0t ns: %s", $time, what);
    endtask

    // ############################################################
    // Monitor that samples at the rising edge.
    // ############################################################
    always @(posedge clk) begin
        if (rst) begin
            cyc = 0;
            inFlight = 0;
            prevRspValid = 0;
            prevHeld = 0;
            readyDue = 0;
            expectQ.delete();
        end else begin
            cyc++;
            if (readyDue) assert (reqReady) else protocolError("reqReady stayed low");
            readyDue = 0;
            if (prevHeld) begin                                   // Back-pressure hold.
                assert (rspValid) else protocolError("rspValid dropped before the transfer");
                assert (rsp == heldRsp) else mismatch("rsp", heldRsp, rsp);
            end
            if (rspValid) assert (!reqReady) else protocolError("reqReady high with rspValid");
            if (inFlight && !rspValid && stall) stallCnt++;       // Each one adds a cycle.
            if (rspValid && !prevRspValid) begin
                if (!inFlight) protocolError("response with no request outstanding");
                else assert (cyc - acceptCyc == expLatency + stallCnt)
                    else mismatch("rspValid latency", expLatency + stallCnt, cyc - acceptCyc);
            end
            if (rspValid && rspReady) begin                       // Transfer.
                if (expectQ.size() == 0) begin
                    protocolError("transfer with an empty scoreboard");
                end else begin
                    want = expectQ.pop_front();
                    assert (rsp.value == want.value)
                        else mismatch("rsp.value", want.value, rsp.value);
                    assert (rsp.tag == want.tag)
                        else mismatch("rsp.tag", want.tag, rsp.tag);
                end
                inFlight = 0;
                readyDue = 1;
            end
            prevHeld = rspValid && !rspReady;
            heldRsp = rsp;
            prevRspValid = rspValid;
            if (flush) begin                                      // Flushed op never answers.
                expectQ.delete();
                inFlight = 0;
                prevHeld = 0;
                readyDue = 1;
            end else if (reqValid && reqReady) begin              // Acceptance in cycle 0.
                want.value = expectValue(req.funct3, req.src1, req.src2);
                want.tag = req.tag;
                expectQ.push_back(want);
                inFlight = 1;
                acceptCyc = cyc;
                stallCnt = 0;
                expLatency = baseLatency(req.funct3);
            end
        end
    end

    // ############################################################
    // Driver that changes inputs 1 ns after the edge.
    // ############################################################
    task automatic sendRequest(input Rv32mFunct3 op, input logic [31:0] a, b);
        int t;
        reqValid = 1;
        req.funct3 = op;
        req.src1 = a;
        req.src2 = b;
        req.tag = nextTag;
        nextTag++;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!reqReady && t < 100);
        #1 reqValid = 0;
        if (t >= 100) protocolError("request not accepted within 100 cycles");
    endtask

    task automatic runOperation(input Rv32mFunct3 op, input logic [31:0] a, b,
                                input int stallCycles, input int holdCycles);
        int t;
        rspReady = (holdCycles == 0);
        sendRequest(op, a, b);
        if (stallCycles > 0) begin                        // Stall from cycle 2 on.
            @(posedge clk);
            #1 stall = 1;
            repeat (stallCycles) @(posedge clk);
            #1 stall = 0;
        end
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!rspValid && t < 100);
        if (t >= 100) protocolError("no response within 100 cycles");
        else if (holdCycles > 0) begin
            repeat (holdCycles) @(posedge clk);
            #1 rspReady = 1;
            @(posedge clk);                                 // Transfer edge.
        end
        #1;
    endtask

    task automatic flushDuring(input Rv32mFunct3 op, input int delay);
        sendRequest(op, $random(seed), $random(seed));
        repeat (delay) @(posedge clk);
        #1 flush = 1;
        @(posedge clk);
        #1 flush = 0;
        repeat (40) @(posedge clk);                         // Monitor flags any late response.
        #1 runOperation(op, $random(seed), $random(seed), 0, 0);
    endtask

    task automatic finishTest(input string name);
        if (errors == errorsAtStart) begin
            passCount++;
            $display("%s ok", name);
        end else begin
            failCount++;
            $display("%s %0d errors", name, errors - errorsAtStart);
        end
        errorsAtStart = errors;
    endtask

    initial begin
        clk = 0;
        rst = 1;
        reqValid = 0;
        req = '0;
        rspReady = 1;
        stall = 0;
        flush = 0;
        seed = 53;
        nextTag = '0;
        errors = 0;
        errorsAtStart = 0;
        passCount = 0;
        failCount = 0;
        repeat (3) @(posedge clk);
        #1 rst = 0;
        @(posedge clk);                                     // First cycle out of reset.
        assert (!rspValid) else mismatch("rspValid", 0, rspValid);
        assert (reqReady) else mismatch("reqReady", 1, reqReady);
        #1 finishTest("reset");
        for (int i = 0; i < NumRandom; i++) begin
            runOperation(Rv32mFunct3'(i % 8), $random(seed), $random(seed), 0, 0);
        end
        finishTest("random");
        for (int f = 0; f < 8; f++) begin                   // Zero divisor, overflow, MULH*.
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    runOperation(Rv32mFunct3'(f), corner[i], corner[j], 0, 0);
                end
            end
        end
        finishTest("corners");
        runOperation(Funct3Mul, $random(seed), $random(seed), 1, 0);
        runOperation(Funct3Mulhsu, $random(seed), $random(seed), 3, 0);
        runOperation(Funct3Div, $random(seed), $random(seed), 1, 0);
        runOperation(Funct3Remu, $random(seed), $random(seed), 3, 0);
        finishTest("stall latency");
        runOperation(Funct3Mulhu, $random(seed), $random(seed), 0, 4);
        runOperation(Funct3Rem, $random(seed), $random(seed), 0, 2);
        finishTest("back-pressure");
        flushDuring(Funct3Mulh, 1);
        flushDuring(Funct3Divu, 10);
        finishTest("flush");
        if (expectQ.size() != 0) protocolError("responses missing at the end");
        $display("Summary: %0d tests ok, %0d tests failing", passCount, failCount);
        if (failCount == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the operation count.
    initial begin
        #(TimeLimit);
        $display("Watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- design/MulDivTop.sv
`timescale 1ns/100ps
`include "MulDiv_consts.svh"

module MulDivTop
    import MulDivOpTypes::*;
    import MulDivPipeTypes::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          reqValid,
    input  MulDivRequest  req,
    output logic          reqReady,
    output logic          rspValid,
    output MulDivResponse rsp,
    input  logic          rspReady,
    input  logic          stall,
    input  logic          flush
);
    MulDivCommand             command;
    logic [`MULDIV_XLEN-1:0]  src1;
    logic [`MULDIV_XLEN-1:0]  src2;
    logic [`MULDIV_TAG_W-1:0] tag;     // Held destination.
    logic                     enable;
    logic                     done;
    logic [`MULDIV_XLEN-1:0]  result;
    logic                     free;    // No operation outstanding.

    // Request side.
    MulDivIssue issue (
        .clk, .rst, .flush, .reqValid, .req, .free, .reqReady,
        .command, .src1, .src2, .tag, .enable
    );

    // Multiplier and divider.
    MulDivUnit unit (
        .done, .result, .command, .src1, .src2, .enable, .stall, .flush, .clk, .rst
    );

    // Response side.
    MulDivWriteback writeback (
        .clk, .rst, .flush, .enable, .done, .result, .tag,
        .rspReady, .rspValid, .rsp, .free
    );

endmodule

//--- design/MulDivWriteback.sv
`timescale 1ns/100ps
`include "MulDiv_consts.svh"

module MulDivWriteback
    import MulDivPipeTypes::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     enable,   // Operation started.
    input  logic                     done,
    input  logic [`MULDIV_XLEN-1:0]  result,
    input  logic [`MULDIV_TAG_W-1:0] tag,
    input  logic                     rspReady,
    output logic                     rspValid,
    output MulDivResponse            rsp,
    output logic                     free
);
    typedef enum logic [1:0] {
        WbIdle, // Nothing outstanding.
        WbBusy, // Unit is working.
        WbHold  // Response waits for the core.
    } WbState;

    WbState state;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= WbIdle; // A flushed operation never answers.
        end else begin
            case (state)
                WbIdle:  if (enable) state <= WbBusy;
                WbBusy:  if (done) state <= WbHold;
                default: if (rspReady) state <= WbIdle; // Transfer.
            endcase
        end
    end

    // Response register, loaded once per operation and steady while held.
    always_ff @(posedge clk) begin
        if (state == WbBusy && done) begin
            rsp.value <= result;
            rsp.tag <= tag;
        end
    end

    assign rspValid = (state == WbHold);
    assign free = (state == WbIdle) && !enable; // Low already in the enable cycle.

endmodule

//--- design/MulDivUnit.sv
`timescale 1ns/100ps
`include "MulDiv_consts.svh"

module MulDivUnit
    import MulDivOpTypes::*;
(
    output logic                    done,
    output logic [`MULDIV_XLEN-1:0] result,
    input  MulDivCommand            command,
    input  logic [`MULDIV_XLEN-1:0] src1,
    input  logic [`MULDIV_XLEN-1:0] src2,
    input  logic                    enable,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    clk,
    input  logic                    rst
);
    logic                    startPending; // Enable seen while stalled.
    logic                    start;
    logic                    mulStart;     // Start for multiply commands only.
    logic                    divStart;     // Start for divide and remainder commands.
    logic                    mulDone;
    logic [`MULDIV_XLEN-1:0] mulResult;
    logic                    mulHigh;
    logic                    mulSrc1Signed;
    logic                    mulSrc2Signed;
    logic                    divDone;
    logic [`MULDIV_XLEN-1:0] quotient;
    logic [`MULDIV_XLEN-1:0] remnant;
    logic                    divSigned;
    logic                    isMul;

    // The enable pulse is kept until the first unstalled cycle.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            startPending <= 1'b0;
        end else if (stall && enable) begin
            startPending <= 1'b1;
        end else if (!stall) begin
            startPending <= 1'b0;
        end
    end
    assign start = enable || startPending;

    // Only the unit that owns the command runs, so the divider is idle for the next one.
    assign mulStart = start && isMul;
    assign divStart = start && !isMul;

    MulUnit mulUnit (
        .done(mulDone), .result(mulResult), .high(mulHigh),
        .src1Signed(mulSrc1Signed), .src2Signed(mulSrc2Signed),
        .src1, .src2, .enable(mulStart), .stall, .flush, .clk, .rst
    );

    DivUnit #(
        .N(`MULDIV_XLEN)
    ) divUnit (
        .done(divDone), .quotient, .remnant, .isSigned(divSigned),
        .dividend(src1), .divisor(src2), .enable(divStart), .stall, .flush, .clk, .rst
    );

    // Controls from the command.
    assign isMul = (command == MulDivCommand_Mul) || mulHigh;
    assign mulHigh = (command == MulDivCommand_Mulh) || (command == MulDivCommand_Mulhsu) ||
                     (command == MulDivCommand_Mulhu);
    assign mulSrc1Signed = (command == MulDivCommand_Mulh) || (command == MulDivCommand_Mulhsu);
    assign mulSrc2Signed = (command == MulDivCommand_Mulh);
    assign divSigned = (command == MulDivCommand_Div) || (command == MulDivCommand_Rem);

    // Output steering.
    always_comb begin
        if (isMul) begin
            done = mulDone;
            result = mulResult;
        end else if (command == MulDivCommand_Div || command == MulDivCommand_Divu) begin
            done = divDone;
            result = quotient;
        end else begin
            done = divDone;  // REM and REMU.
            result = remnant;
        end
    end

endmodule

//--- design/DivUnit.sv
`timescale 1ns/100ps

module DivUnit #(
    parameter int N = 32
) (
    output logic         done,
    output logic [N-1:0] quotient,
    output logic [N-1:0] remnant,
    input  logic         isSigned,
    input  logic [N-1:0] dividend,
    input  logic [N-1:0] divisor,
    input  logic         enable,
    input  logic         stall,
    input  logic         flush,
    input  logic         clk,
    input  logic         rst
);
    typedef enum logic [1:0] {
        DivIdle, // Waiting for enable.
        DivRun,  // N shift-subtract steps.
        DivFix   // Signs applied, done high.
    } DivState;

    DivState              state;
    logic [$clog2(N)-1:0] count;       // Steps left minus one.
    logic [N-1:0]         quo;         // Dividend bits out, quotient bits in.
    logic [N-1:0]         rem;         // Partial remainder.
    logic [N-1:0]         dvsr;        // Divisor magnitude.
    logic                 quoNeg;
    logic                 remNeg;
    logic                 overflow;    // Most-negative / -1.
    logic                 dividendNeg;
    logic                 divisorNeg;
    logic [N:0]           shifted;     // Remainder with the next dividend bit.
    logic [N:0]           diff;        // Trial subtraction, bit N is the borrow.

    assign dividendNeg = isSigned && dividend[N-1];
    assign divisorNeg = isSigned && divisor[N-1];
    assign shifted = {rem, quo[N-1]};
    assign diff = shifted - {1'b0, dvsr};

    // ############################################################
    // Control.
    // ############################################################
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= DivIdle;
        end else if (!stall) begin
            case (state)
                DivIdle: if (enable) state <= DivRun;
                DivRun:  if (count == '0) state <= DivFix; // Last step.
                default: state <= DivIdle;                 // Result taken in DivFix.
            endcase
        end
    end

    // ############################################################
    // Datapath.
    // ############################################################
    always_ff @(posedge clk) begin
        if (!stall) begin
            if (state == DivIdle && enable) begin
                // Work on magnitudes, remember the signs.
                quo <= dividendNeg ? -dividend : dividend;
                dvsr <= divisorNeg ? -divisor : divisor;
                rem <= '0;
                count <= $clog2(N)'(N - 1);
                // A zero divisor keeps the all-ones quotient unsigned.
                quoNeg <= (dividendNeg ^ divisorNeg) && (divisor != '0);
                remNeg <= dividendNeg; // Remainder follows the dividend.
                overflow <= dividendNeg && (dividend[N-2:0] == '0) && divisorNeg && (&divisor);
            end else if (state == DivRun) begin
                count <= count - 1'b1;
                if (!diff[N]) begin // No borrow, keep the difference.
                    rem <= diff[N-1:0];
                    quo <= {quo[N-2:0], 1'b1};
                end else begin      // Restore.
                    rem <= shifted[N-1:0];
                    quo <= {quo[N-2:0], 1'b0};
                end
            end
        end
    end

    // Fix-up, visible while the state is DivFix.
    always_comb begin
        quotient = quoNeg ? -quo : quo;
        remnant = remNeg ? -rem : rem;
        if (overflow) begin
            quotient = {1'b1, {(N-1){1'b0}}}; // Dividend comes back unchanged.
            remnant = '0;
        end
    end

    assign done = (state == DivFix) && !stall;

endmodule

//--- design/MulUnit.sv
`timescale 1ns/100ps
`include "MulDiv_consts.svh"

module MulUnit (
    output logic                    done,
    output logic [`MULDIV_XLEN-1:0] result,
    input  logic                    high,
    input  logic                    src1Signed,
    input  logic                    src2Signed,
    input  logic [`MULDIV_XLEN-1:0] src1,
    input  logic [`MULDIV_XLEN-1:0] src2,
    input  logic                    enable,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    clk,
    input  logic                    rst
);
    localparam int W = `MULDIV_XLEN;
    localparam int LAT = `MULDIV_MUL_LATENCY;

    // One valid bit per stage; the datapath below is built as three stages.
    logic [LAT-1:0] valid;

    // Stage 1: operands extended to 33 bits.
    logic signed [W:0] opA;
    logic signed [W:0] opB;
    logic              high1;

    // Stage 2: full product.
    logic signed [2*W+1:0] product;
    logic                  high2;

    // Stage 3: selected word.
    logic [W-1:0] word;

    // ############################################################
    // Valid chain.
    // ############################################################
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid <= '0;
        end else if (!stall) begin
            valid <= {valid[LAT-2:0], enable}; // Shift one stage per cycle.
        end
    end

    // ############################################################
    // Datapath; stall freezes every stage.
    // ############################################################
    always_ff @(posedge clk) begin
        if (!stall) begin
            opA <= {src1Signed & src1[W-1], src1}; // Sign or zero extension.
            opB <= {src2Signed & src2[W-1], src2};
            high1 <= high;

            product <= opA * opB; // 33 x 33 signed covers all three sign modes.
            high2 <= high1;

            // MULH* take bits 63:32, MUL takes 31:0.
            word <= high2 ? product[2*W-1:W] : product[W-1:0];
        end
    end

    // Done drops during a stall so the result is taken exactly once.
    assign done = valid[LAT-1] && !stall;
    assign result = word;

endmodule

//--- design/MulDivIssue.sv
`timescale 1ns/100ps
`include "MulDiv_consts.svh"

module MulDivIssue
    import MulDivOpTypes::*;
    import MulDivPipeTypes::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     reqValid,
    input  MulDivRequest             req,
    input  logic                     free,
    output logic                     reqReady,
    output MulDivCommand             command,
    output logic [`MULDIV_XLEN-1:0]  src1,
    output logic [`MULDIV_XLEN-1:0]  src2,
    output logic [`MULDIV_TAG_W-1:0] tag,
    output logic                     enable
);
    logic         accept;  // Request transfers on this edge.
    MulDivCommand decoded;

    // Only one operation in flight, so ready follows the write-back side.
    assign reqReady = free;
    assign accept = reqValid && reqReady && !flush; // A flush wins over a new request.

    // funct3 to command.
    always_comb begin
        case (req.funct3)
            Funct3Mul:    decoded = MulDivCommand_Mul;
            Funct3Mulh:   decoded = MulDivCommand_Mulh;
            Funct3Mulhsu: decoded = MulDivCommand_Mulhsu;
            Funct3Mulhu:  decoded = MulDivCommand_Mulhu;
            Funct3Div:    decoded = MulDivCommand_Div;
            Funct3Divu:   decoded = MulDivCommand_Divu;
            Funct3Rem:    decoded = MulDivCommand_Rem;
            Funct3Remu:   decoded = MulDivCommand_Remu;
            default:      decoded = MulDivCommand_Mul;
        endcase
    end

    // Control: one-cycle enable, command held until the next request.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            enable <= 1'b0;
            command <= MulDivCommand_Mul;
        end else begin
            enable <= accept; // Pulse in the cycle after acceptance.
            if (accept) begin
                command <= decoded;
            end
        end
    end

    // Operands and tag stay put for the whole operation.
    // The unit reads them again after a stalled start.
    always_ff @(posedge clk) begin
        if (accept) begin
            src1 <= req.src1;
            src2 <= req.src2;
            tag <= req.tag;
        end
    end

endmodule

//--- design/MulDivPipeTypes.sv
`include "MulDiv_consts.svh"

package MulDivPipeTypes;
    import MulDivOpTypes::*;

    // ############################################################
    // Issue stage to unit.
    // ############################################################
    typedef struct packed {
        Rv32mFunct3               funct3; // Operation select.
        logic [`MULDIV_XLEN-1:0]  src1;   // rs1 value.
        logic [`MULDIV_XLEN-1:0]  src2;   // rs2 value.
        logic [`MULDIV_TAG_W-1:0] tag;    // Destination register.
    } MulDivRequest;

    // ############################################################
    // Unit to write-back stage.
    // ############################################################
    typedef struct packed {
        logic [`MULDIV_XLEN-1:0]  value;  // Result word.
        logic [`MULDIV_TAG_W-1:0] tag;    // Copied from the request.
    } MulDivResponse;

endpackage

//--- design/MulDivOpTypes.sv
package MulDivOpTypes;

    // funct3 field of the RV32M OP instructions, as the issue stage hands it over.
    typedef enum logic [2:0] {
        Funct3Mul    = 3'b000,
        Funct3Mulh   = 3'b001,
        Funct3Mulhsu = 3'b010,
        Funct3Mulhu  = 3'b011,
        Funct3Div    = 3'b100,
        Funct3Divu   = 3'b101,
        Funct3Rem    = 3'b110,
        Funct3Remu   = 3'b111
    } Rv32mFunct3;

    // Internal command that steers the unit.
    typedef enum logic [2:0] {
        MulDivCommand_Mul,    // Low word, any sign.
        MulDivCommand_Mulh,   // High word, signed x signed.
        MulDivCommand_Mulhsu, // High word, signed x unsigned.
        MulDivCommand_Mulhu,  // High word, unsigned x unsigned.
        MulDivCommand_Div,
        MulDivCommand_Divu,
        MulDivCommand_Rem,
        MulDivCommand_Remu
    } MulDivCommand;

endpackage

//--- design/MulDiv_consts.svh
`ifndef MULDIV_CONSTS_SVH
`define MULDIV_CONSTS_SVH

// ############################################################
// Widths of the multiply/divide datapath.
// ############################################################

// Operand and result width, one RV32 word.
`define MULDIV_XLEN 32

// Destination register tag, x0..x31.
`define MULDIV_TAG_W 5

// ############################################################
// Timing.
// ############################################################

// Cycles from enable to done in the multiplier.
`define MULDIV_MUL_LATENCY 3

`endif
